// File: include/fc_config.svh
`ifndef FC_CONFIG_SVH
`define FC_CONFIG_SVH

// output classes
`define FC_NEURONS 10

// pooled channels, one feature each per group
`define FC_CHANNELS 6

// two passes of 16 groups
`define FC_GROUPS 32

// one weight bit per feature of the image
`define FC_WEIGHTS 192

`define FC_DATA_W 32

`endif

// File: design/cnn_data_pkg.sv
`include "fc_config.svh"

package cnn_data_pkg;

    // one pooled feature, two's complement
    typedef logic signed [`FC_DATA_W-1:0] feature_t;

    // channel 0 in the low word
    typedef feature_t [`FC_CHANNELS-1:0] feature_group_t;

    // running sum and final class score, wraps on overflow
    typedef logic signed [`FC_DATA_W-1:0] acc_t;

endpackage

// File: design/cnn_ctrl_pkg.sv
`include "fc_config.svh"

package cnn_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_WEIGHTS,
        ACCEPT_FEATURES
    } feeder_state_t;

    // neuron under load, also the output slot in the drain
    typedef logic [$clog2(`FC_NEURONS)-1:0] neuron_idx_t;

    typedef logic [$clog2(`FC_GROUPS)-1:0] group_idx_t;

endpackage

// File: design/fc_bus_if.sv
`timescale 1ns/10ps
`include "fc_config.svh"

// broadcast from the feeder to every neuron
interface fc_bus_if import cnn_data_pkg::*; ();

    logic                   clear;    // empties all accumulators
    logic                   w_valid;
    logic                   w_bit;
    logic [`FC_NEURONS-1:0] w_sel;    // one-hot, neuron taking w_bit
    logic                   f_valid;
    feature_group_t         f_group;
    logic                   f_last;   // last group of the image

    modport feeder (
        output clear,
        output w_valid,
        output w_bit,
        output w_sel,
        output f_valid,
        output f_group,
        output f_last
    );

    // w_sel is split per neuron at the top level
    modport neuron (
        input clear,
        input w_valid,
        input w_bit,
        input f_valid,
        input f_group,
        input f_last
    );

endinterface

// File: design/fc_feeder.sv
`timescale 1ns/10ps
`include "fc_config.svh"

module fc_feeder import cnn_data_pkg::*, cnn_ctrl_pkg::*; (
    input  logic           clk,
    input  logic           rstn,
    input  logic           start,
    input  logic           weight_tvalid,
    input  logic           weight_tdata,
    output logic           weight_tready,
    input  logic           feature_valid,
    input  feature_group_t feature_data,
    fc_bus_if.feeder       bus
);

    localparam int BIT_W = $clog2(`FC_WEIGHTS);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`FC_WEIGHTS - 1);
    localparam neuron_idx_t NEURON_LAST = neuron_idx_t'(`FC_NEURONS - 1);
    localparam group_idx_t GROUP_LAST = group_idx_t'(`FC_GROUPS - 1);

    feeder_state_t    state;
    neuron_idx_t      neuron_idx;
    logic [BIT_W-1:0] bit_cnt;      // bit within the current neuron
    group_idx_t       group_idx;
    logic             w_fire;
    logic             f_take;
    logic             last_weight;
    logic             last_group;

    assign w_fire      = weight_tvalid && weight_tready;
    assign f_take      = feature_valid && (state == ACCEPT_FEATURES);  // dropped elsewhere
    assign last_weight = (neuron_idx == NEURON_LAST) && (bit_cnt == BIT_LAST);
    assign last_group  = (group_idx == GROUP_LAST);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state         <= IDLE;
            weight_tready <= 1'b0;
            neuron_idx    <= '0;
            bit_cnt       <= '0;
            group_idx     <= '0;
            bus.clear     <= 1'b0;
            bus.w_valid   <= 1'b0;
            bus.f_valid   <= 1'b0;
            bus.f_last    <= 1'b0;
        end else begin
            bus.clear   <= 1'b0;
            bus.w_valid <= w_fire;
            bus.f_valid <= f_take;
            bus.f_last  <= f_take && last_group;
            case (state)
                IDLE: begin
                    if (start) begin
                        state         <= LOAD_WEIGHTS;
                        weight_tready <= 1'b1;
                        bus.clear     <= 1'b1;
                        neuron_idx    <= '0;
                        bit_cnt       <= '0;
                        group_idx     <= '0;
                    end
                end
                LOAD_WEIGHTS: begin
                    if (w_fire) begin
                        if (bit_cnt == BIT_LAST) begin
                            bit_cnt    <= '0;
                            neuron_idx <= neuron_idx + 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        // 1920th transfer closes the load phase
                        if (last_weight) begin
                            weight_tready <= 1'b0;
                            state         <= ACCEPT_FEATURES;
                        end
                    end
                end
                ACCEPT_FEATURES: begin
                    if (f_take) begin
                        group_idx <= group_idx + 1'b1;  // wraps to 0 after the image
                        if (last_group)
                            state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (w_fire) begin
            bus.w_bit <= weight_tdata;
            bus.w_sel <= {{(`FC_NEURONS-1){1'b0}}, 1'b1} << neuron_idx;
        end
        if (f_take)
            bus.f_group <= feature_data;
    end

    // the port handshake may only open during the load phase
    a_ready_in_load: assert property (
        @(posedge clk) disable iff (!rstn)
        weight_tready |-> (state == LOAD_WEIGHTS)
    );

endmodule

// File: design/fc_neuron.sv
`timescale 1ns/10ps
`include "fc_config.svh"

module fc_neuron import cnn_data_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  logic     sel,
    fc_bus_if.neuron bus,
    output acc_t     sum,
    output logic     sum_valid
);

    // bit k = group*6 + channel, first bit loaded ends up at bit 0
    logic [`FC_WEIGHTS-1:0] weights;
    acc_t                   acc;
    acc_t                   term;
    acc_t                   acc_next;

    always_ff @(posedge clk) begin
        if (sel && bus.w_valid)
            weights <= {bus.w_bit, weights[`FC_WEIGHTS-1:1]};
        else if (bus.f_valid)
            // rotate, so the store is intact again after 32 groups
            weights <= {weights[`FC_CHANNELS-1:0], weights[`FC_WEIGHTS-1:`FC_CHANNELS]};
    end

    // binary weight: 1 adds the feature, 0 subtracts it
    always_comb begin
        term = '0;
        for (int c = 0; c < `FC_CHANNELS; c++) begin
            if (weights[c])
                term = term + bus.f_group[c];
            else
                term = term - bus.f_group[c];
        end
    end

    assign acc_next = acc + term;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc       <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= bus.f_valid && bus.f_last;
            if (bus.clear)
                acc <= '0;
            else if (bus.f_valid)
                acc <= acc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.f_valid && bus.f_last)
            sum <= acc_next;   // includes the last group
    end

    // loading and feature phases never overlap on the bus
    a_no_overlap: assert property (
        @(posedge clk) disable iff (!rstn)
        !(bus.f_valid && bus.w_valid)
    );

endmodule

// File: design/fc_result_drain.sv
`timescale 1ns/10ps
`include "fc_config.svh"

module fc_result_drain import cnn_data_pkg::*, cnn_ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start,
    input  acc_t                   sum [`FC_NEURONS],
    input  logic [`FC_NEURONS-1:0] sum_valid,
    output logic                   result_tvalid,
    output acc_t                   result_tdata,
    output logic                   cnn_done
);

    localparam neuron_idx_t LAST_IDX = neuron_idx_t'(`FC_NEURONS - 1);

    acc_t        hold [`FC_NEURONS];
    neuron_idx_t out_idx;
    logic        capture;

    assign capture = &sum_valid;  // all neurons finish on the same cycle

    always_ff @(posedge clk) begin
        if (capture)
            hold <= sum;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            result_tvalid <= 1'b0;
            out_idx       <= '0;
            cnn_done      <= 1'b0;
        end else begin
            if (capture) begin
                result_tvalid <= 1'b1;
                out_idx       <= '0;
            end else if (result_tvalid) begin
                if (out_idx == LAST_IDX) begin
                    result_tvalid <= 1'b0;
                    cnn_done      <= 1'b1;
                end else begin
                    out_idx <= out_idx + 1'b1;
                end
            end
            if (start)
                cnn_done <= 1'b0;   // held until the next image
        end
    end

    assign result_tdata = hold[out_idx];  // neuron 0 first

    // done only after the last result has left
    a_done_after_drain: assert property (
        @(posedge clk) disable iff (!rstn)
        !(result_tvalid && cnn_done)
    );

endmodule

// File: design/fc_classifier_top.sv
`timescale 1ns/10ps
`include "fc_config.svh"

module fc_classifier_top import cnn_data_pkg::*; (
    input  logic           clk,
    input  logic           rstn,
    input  logic           start,
    input  logic           weight_tvalid,
    input  logic           weight_tdata,
    output logic           weight_tready,
    input  logic           feature_valid,
    input  feature_group_t feature_data,
    output logic           result_tvalid,
    output acc_t           result_tdata,
    output logic           cnn_done
);

    fc_bus_if bus ();

    acc_t                   sum [`FC_NEURONS];
    logic [`FC_NEURONS-1:0] sum_valid;

    fc_feeder u_feeder (
        .clk           (clk),
        .rstn          (rstn),
        .start         (start),
        .weight_tvalid (weight_tvalid),
        .weight_tdata  (weight_tdata),
        .weight_tready (weight_tready),
        .feature_valid (feature_valid),
        .feature_data  (feature_data),
        .bus           (bus.feeder)
    );

    // one neuron per class, each on its own select line
    for (genvar i = 0; i < `FC_NEURONS; i++) begin : g_neuron
        fc_neuron u_neuron (
            .clk       (clk),
            .rstn      (rstn),
            .sel       (bus.w_sel[i]),
            .bus       (bus.neuron),
            .sum       (sum[i]),
            .sum_valid (sum_valid[i])
        );
    end

    fc_result_drain u_drain (
        .clk           (clk),
        .rstn          (rstn),
        .start         (start),
        .sum           (sum),
        .sum_valid     (sum_valid),
        .result_tvalid (result_tvalid),
        .result_tdata  (result_tdata),
        .cnn_done      (cnn_done)
    );

endmodule

// File: tb/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // released on the third rising edge
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// File: tb/tb_fc_classifier.sv
`timescale 1ns/10ps
`include "fc_config.svh"

module tb_fc_classifier import cnn_data_pkg::*; ();

    localparam int TOTAL_W      = `FC_NEURONS * `FC_WEIGHTS;
    localparam int LOAD_LIMIT   = 20000;
    localparam int RESULT_LIMIT = 40;

    logic           clk;
    logic           rstn;
    logic           start;
    logic           weight_tvalid;
    logic           weight_tdata;
    logic           weight_tready;
    logic           feature_valid;
    feature_group_t feature_data;
    logic           result_tvalid;
    acc_t           result_tdata;
    logic           cnn_done;

    logic [`FC_WEIGHTS-1:0] wmem [`FC_NEURONS];  // bit k = group*6 + channel
    feature_group_t         fmem [`FC_GROUPS];
    acc_t                   expected [`FC_NEURONS];
    logic [31:0]            lfsr_state;
    int                     errors;
    int                     err_mark;
    int                     tests_run;
    int                     tests_failed;
    bit                     timed_out;

    tb_clkgen u_clkgen (
        .clk  (clk),
        .rstn (rstn)
    );

    fc_classifier_top DUT (
        .clk           (clk),
        .rstn          (rstn),
        .start         (start),
        .weight_tvalid (weight_tvalid),
        .weight_tdata  (weight_tdata),
        .weight_tready (weight_tready),
        .feature_valid (feature_valid),
        .feature_data  (feature_data),
        .result_tvalid (result_tvalid),
        .result_tdata  (result_tdata),
        .cnn_done      (cnn_done)
    );

    // galois lfsr with taps from x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb)
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], next_bit()};
        return v;
    endfunction

    // 16-bit signed features keep every sum far from wrapping
    function automatic feature_group_t random_group();
        feature_group_t grp;
        logic [15:0]    r;
        for (int c = 0; c < `FC_CHANNELS; c++) begin
            r = 16'(rand_bits(16));
            grp[c] = feature_t'($signed(r));
        end
        return grp;
    endfunction

    function automatic acc_t model_sum(input int n);
        acc_t s;
        acc_t sign;
        s = '0;
        for (int g = 0; g < `FC_GROUPS; g++) begin
            for (int c = 0; c < `FC_CHANNELS; c++) begin
                sign = wmem[n][g * `FC_CHANNELS + c] ? 1 : -1;
                s = s + sign * fmem[g][c];
            end
        end
        return s;
    endfunction

    task automatic make_image();
        for (int n = 0; n < `FC_NEURONS; n++)
            for (int k = 0; k < `FC_WEIGHTS; k++)
                wmem[n][k] = next_bit();
        for (int g = 0; g < `FC_GROUPS; g++)
            fmem[g] = random_group();
        for (int n = 0; n < `FC_NEURONS; n++)
            expected[n] = model_sum(n);
    endtask

    task automatic report_mismatch(input string name, input logic signed [31:0] exp,
                                   input logic signed [31:0] got);
        errors++;
        $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rstn !== 1'b1 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (rstn !== 1'b1) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end
    endtask

    // junk puts feature strobes on the edges around start
    task automatic start_image(input bit junk);
        @(posedge clk);
        start         <= 1'b1;
        feature_valid <= junk;
        feature_data  <= random_group();
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        if (weight_tready !== 1'b1)
            report_mismatch("weight_tready", 1, weight_tready);
        if (cnn_done !== 1'b0)
            report_mismatch("cnn_done", 0, cnn_done);
    endtask

    task automatic load_weights(input bit gaps, input bit junk);
        int   taken;
        int   cycles;
        logic ready_seen;
        taken = 0;
        cycles = 0;
        ready_seen = weight_tready;
        while (taken < TOTAL_W && cycles < LOAD_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (weight_tvalid && ready_seen)
                taken++;   // transfer on this edge
            if (taken < TOTAL_W) begin
                weight_tvalid <= gaps ? next_bit() : 1'b1;
                weight_tdata  <= wmem[taken / `FC_WEIGHTS][taken % `FC_WEIGHTS];
                feature_valid <= junk ? next_bit() : 1'b0;
                feature_data  <= random_group();
            end else begin
                weight_tvalid <= 1'b0;
                feature_valid <= 1'b0;
            end
            @(negedge clk);
            ready_seen = weight_tready;
        end
        if (taken < TOTAL_W) begin
            $display("timeout: only %0d of %0d weights were accepted", taken, TOTAL_W);
            timed_out = 1'b1;
        end else begin
            if (ready_seen !== 1'b0)
                report_mismatch("weight_tready", 0, ready_seen);
            // extra offers must not be taken
            repeat (3) begin
                @(posedge clk);
                weight_tvalid <= 1'b1;
                @(negedge clk);
                if (weight_tready !== 1'b0)
                    report_mismatch("weight_tready", 0, weight_tready);
            end
            @(posedge clk);
            weight_tvalid <= 1'b0;
        end
    endtask

    task automatic send_features(input bit gaps);
        int idle;
        for (int g = 0; g < `FC_GROUPS; g++) begin
            idle = gaps ? int'(rand_bits(2)) : 0;
            repeat (idle) begin
                @(posedge clk);
                feature_valid <= 1'b0;
            end
            @(posedge clk);
            feature_valid <= 1'b1;
            feature_data  <= fmem[g];
        end
    endtask

    task automatic collect_results(input bit check_delay);
        int edges;
        bit found;
        edges = 0;
        found = 1'b0;
        while (!found && edges < RESULT_LIMIT) begin
            @(posedge clk);
            feature_valid <= 1'b0;
            edges++;
            @(negedge clk);
            found = (result_tvalid === 1'b1);
        end
        if (!found) begin
            $display("timeout: no result within %0d cycles of the last group", RESULT_LIMIT);
            timed_out = 1'b1;
        end else begin
            if (check_delay && edges != 3)
                report_mismatch("result_tvalid delay", 3, edges);
            for (int n = 0; n < `FC_NEURONS; n++) begin
                if (n > 0) begin
                    @(posedge clk);
                    @(negedge clk);
                end
                if (result_tvalid !== 1'b1)
                    report_mismatch("result_tvalid", 1, result_tvalid);
                if (result_tdata !== expected[n])
                    report_mismatch($sformatf("result_tdata[%0d]", n), expected[n], result_tdata);
                if (cnn_done !== 1'b0)
                    report_mismatch("cnn_done", 0, cnn_done);
            end
            @(posedge clk);
            @(negedge clk);
            if (result_tvalid !== 1'b0)
                report_mismatch("result_tvalid", 0, result_tvalid);
            repeat (5) begin   // done holds while idle
                if (cnn_done !== 1'b1)
                    report_mismatch("cnn_done", 1, cnn_done);
                @(posedge clk);
                @(negedge clk);
            end
        end
    endtask

    task automatic end_test(input int num, input string what);
        tests_run++;
        if (errors == err_mark && !timed_out) begin
            $display("test %0d %s: ok", num, what);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, what, errors - err_mark);
        end
    endtask

    initial begin
        start         = 1'b0;
        weight_tvalid = 1'b0;
        weight_tdata  = 1'b0;
        feature_valid = 1'b0;
        feature_data  = '0;
        lfsr_state    = 32'h0e92_aa26;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        timed_out     = 1'b0;

        wait_reset();
        if (!timed_out) begin
            err_mark = errors;
            make_image();
            if (weight_tready !== 1'b0)
                report_mismatch("weight_tready", 0, weight_tready);
            if (result_tvalid !== 1'b0)
                report_mismatch("result_tvalid", 0, result_tvalid);
            if (cnn_done !== 1'b0)
                report_mismatch("cnn_done", 0, cnn_done);
            start_image(1'b0);
            end_test(1, "reset values and start");
        end
        if (!timed_out) begin
            err_mark = errors;
            load_weights(1'b1, 1'b0);
            end_test(2, "weight load with random gaps");
        end
        if (!timed_out) begin
            err_mark = errors;
            send_features(1'b0);
            collect_results(1'b1);
            end_test(3, "back-to-back feature groups");
        end
        if (!timed_out) begin
            err_mark = errors;
            make_image();
            start_image(1'b0);
            load_weights(1'b1, 1'b0);
            send_features(1'b1);
            collect_results(1'b0);
            end_test(4, "feature groups with random gaps");
        end
        if (!timed_out) begin
            err_mark = errors;
            make_image();
            if (cnn_done !== 1'b1)
                report_mismatch("cnn_done", 1, cnn_done);
            start_image(1'b0);
            load_weights(1'b0, 1'b0);
            send_features(1'b0);
            collect_results(1'b1);
            end_test(5, "restart clears accumulators");
        end
        if (!timed_out) begin
            err_mark = errors;
            make_image();
            start_image(1'b1);
            load_weights(1'b1, 1'b1);
            send_features(1'b1);
            collect_results(1'b0);
            end_test(6, "early feature strobes ignored");
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
design/cnn_data_pkg.sv
design/cnn_ctrl_pkg.sv
design/fc_bus_if.sv
design/fc_feeder.sv
design/fc_neuron.sv
design/fc_result_drain.sv
design/fc_classifier_top.sv
tb/tb_clkgen.sv
tb/tb_fc_classifier.sv

// File: Bender.yml
package:
  name: fc_classifier

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/cnn_data_pkg.sv
      - design/cnn_ctrl_pkg.sv
      - design/fc_bus_if.sv
      - design/fc_feeder.sv
      - design/fc_neuron.sv
      - design/fc_result_drain.sv
      - design/fc_classifier_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clkgen.sv
      - tb/tb_fc_classifier.sv
